/* logic/cpu_pkg.sv */
package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  // fetch address counts words, not bytes
  localparam int pc_width       = 10;

  typedef logic [data_width-1:0]     word_t;
  typedef logic [reg_addr_width-1:0] reg_idx_t;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_beq   = 6'h04,
    op_addi  = 6'h08,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  // values double as the r-type function codes
  typedef enum logic [10:0] {
    alu_add = 11'h020,
    alu_sub = 11'h022,
    alu_and = 11'h024,
    alu_or  = 11'h025,
    alu_slt = 11'h02a
  } alu_op_e;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    alu_op_e  funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  ////////////////////////////////////////////////////////////
  // pipeline stages
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e  alu_op;
    logic     imm_src;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     branch;
    reg_idx_t dst;
  } ctrl_t;

  typedef struct packed {
    logic                valid;
    logic [pc_width-1:0] pc;
    reg_idx_t            rs;
    reg_idx_t            rt;
    word_t               rs_data;
    word_t               rt_data;
    word_t               imm;
    ctrl_t               ctrl;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t dst;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    reg_idx_t dst;
    word_t    data;
  } wb_t;

  typedef struct packed {
    logic                take;
    logic [pc_width-1:0] target;
  } redirect_t;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage import cpu_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall,
  input  redirect_t           redirect,
  output logic [pc_width-1:0] pc
);

  // taken branch beats the load-use hold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (redirect.take) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pc + 1'b1;
    end
  end

  // stall and redirect come from decode and execute, both must stay clean
  a_pc_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(pc)
  );

endmodule

/* logic/register_file.sv */
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rd_idx_a,
  input  reg_idx_t rd_idx_b,
  output word_t    rd_data_a,
  output word_t    rd_data_b,
  input  wb_t      wr
);

  word_t regs [2**reg_addr_width];

  logic wr_en;

  // r0 is never stored
  assign wr_en = wr.valid && wr.reg_write && (wr.dst != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wr.dst] <= wr.data;
    end
  end

  // same-cycle write shows up on the read side
  function automatic word_t read_port(reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wr_en && (wr.dst == idx)) begin
      val = wr.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  assign rd_data_a = read_port(rd_idx_a);
  assign rd_data_b = read_port(rd_idx_b);

  // a zero-destination write must come from a real instruction, not a bubble
  a_zero_write_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr.reg_write && (wr.dst == '0)) |-> wr.valid
  );

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [pc_width-1:0] pc,
  input  word_t               fetch_data,
  input  redirect_t           redirect,
  output reg_idx_t            rd_idx_a,
  output reg_idx_t            rd_idx_b,
  input  word_t               rd_data_a,
  input  word_t               rd_data_b,
  output logic                stall,
  output id_ex_t              id_ex
);

  logic                if_id_valid;
  logic [pc_width-1:0] if_id_pc;
  instr_u              if_id_instr;
  ctrl_t               ctrl;
  word_t               imm_ext;

  ////////////////////////////////////////////////////////////
  // if/id
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_valid <= 1'b0;
      if_id_pc    <= '0;
      if_id_instr <= '0;
    end else if (redirect.take) begin
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      if_id_valid <= 1'b1;
      if_id_pc    <= pc;
      if_id_instr <= fetch_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  // rs and rt sit in the same bits in both formats
  assign rd_idx_a = if_id_instr.r.rs;
  assign rd_idx_b = if_id_instr.r.rt;

  assign imm_ext = {{(data_width-16){if_id_instr.i.imm[15]}}, if_id_instr.i.imm};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    case (if_id_instr.r.opcode)
      op_rtype: begin
        ctrl.alu_op    = if_id_instr.r.funct;
        ctrl.reg_write = 1'b1;
        ctrl.dst       = if_id_instr.r.rd;
      end
      op_addi: begin
        ctrl.imm_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dst       = if_id_instr.i.rt;
      end
      op_lw: begin
        ctrl.imm_src    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.dst        = if_id_instr.i.rt;
      end
      op_sw: begin
        ctrl.imm_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      op_beq: begin
        ctrl.alu_op = alu_sub;
        ctrl.branch = 1'b1;
      end
      // unknown opcodes pass through as no-ops
      default: ;
    endcase
  end

  // load in execute feeding the instruction right behind it
  assign stall = if_id_valid && id_ex.valid && id_ex.ctrl.mem_read &&
                 (id_ex.ctrl.dst != '0) &&
                 ((id_ex.ctrl.dst == rd_idx_a) || (id_ex.ctrl.dst == rd_idx_b));

  ////////////////////////////////////////////////////////////
  // id/ex
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (redirect.take || stall) begin
      // bubble
      id_ex <= '0;
    end else begin
      id_ex.valid   <= if_id_valid;
      id_ex.pc      <= if_id_pc;
      id_ex.rs      <= rd_idx_a;
      id_ex.rt      <= rd_idx_b;
      id_ex.rs_data <= rd_data_a;
      id_ex.rt_data <= rd_data_b;
      id_ex.imm     <= imm_ext;
      id_ex.ctrl    <= ctrl;
    end
  end

  // fetch holds its pc along with if/id so the word behind the stalled one is kept
  a_stall_holds_pc: assert property (
    @(posedge clk) disable iff (!rst_n)
    (stall && !redirect.take) |=> (pc == $past(pc))
  );

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  id_ex_t    id_ex,
  input  wb_t       wb,
  output ex_mem_t   ex_mem,
  output redirect_t redirect
);

  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_result;

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////

  // ex/mem is younger than mem/wb, so it is checked first
  function automatic word_t forward(reg_idx_t idx, word_t rf_val);
    word_t val;
    if (idx == '0) begin
      val = rf_val;
    end else if (ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_to_reg &&
                 (ex_mem.dst == idx)) begin
      val = ex_mem.alu_result;
    end else if (wb.valid && wb.reg_write && (wb.dst == idx)) begin
      val = wb.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  assign op_a  = forward(id_ex.rs, id_ex.rs_data);
  assign op_b  = forward(id_ex.rt, id_ex.rt_data);
  assign alu_b = id_ex.ctrl.imm_src ? id_ex.imm : op_b;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add: alu_result = op_a + alu_b;
      alu_sub: alu_result = op_a - alu_b;
      alu_and: alu_result = op_a & alu_b;
      alu_or:  alu_result = op_a | alu_b;
      alu_slt: alu_result = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_result = '0;
    endcase
  end

  // beq target is relative to the next word
  assign redirect.take   = id_ex.valid && id_ex.ctrl.branch && (op_a == op_b);
  assign redirect.target = id_ex.pc + 1'b1 + id_ex.imm[pc_width-1:0];

  ////////////////////////////////////////////////////////////
  // ex/mem
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= op_b;
      ex_mem.dst        <= id_ex.ctrl.dst;
      ex_mem.reg_write  <= id_ex.valid && id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.valid && id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.valid && id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
    end
  end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage import cpu_pkg::*; #(
  parameter int dmem_depth = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  ex_mem_t ex_mem,
  output wb_t     wb
);

  localparam int addr_bits = $clog2(dmem_depth);

  word_t                dmem [dmem_depth];
  logic [addr_bits-1:0] addr;
  word_t                load_data;

  // word addressed, upper bits of the alu result ignored
  assign addr = ex_mem.alu_result[addr_bits-1:0];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  assign load_data = (ex_mem.valid && ex_mem.mem_read) ? dmem[addr] : '0;

  // mem/wb
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb.valid     <= ex_mem.valid;
      wb.reg_write <= ex_mem.reg_write;
      wb.dst       <= ex_mem.dst;
      wb.data      <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;
    end
  end

  // decode never sets both for one opcode
  a_no_read_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ex_mem.mem_read && ex_mem.mem_write)
  );

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
  parameter int dmem_depth = 256
) (
  input  logic                clk,
  input  logic                rst_n,
  output logic [pc_width-1:0] fetch_addr,
  input  word_t               fetch_data,
  output wb_t                 retire
);

  logic [pc_width-1:0] pc;
  logic                stall;
  redirect_t           redirect;
  reg_idx_t            rd_idx_a;
  reg_idx_t            rd_idx_b;
  word_t               rd_data_a;
  word_t               rd_data_b;
  id_ex_t              id_ex;
  ex_mem_t             ex_mem;
  wb_t                 wb;

  // instruction memory lives outside, answers in the same cycle
  assign fetch_addr = pc;
  // mem/wb is already a register, so it serves as the retire port
  assign retire     = wb;

  fetch_stage i_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .pc       (pc)
  );

  decode_stage i_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .fetch_data (fetch_data),
    .redirect   (redirect),
    .rd_idx_a   (rd_idx_a),
    .rd_idx_b   (rd_idx_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .stall      (stall),
    .id_ex      (id_ex)
  );

  register_file i_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr        (wb)
  );

  execute_stage i_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_ex    (id_ex),
    .wb       (wb),
    .ex_mem   (ex_mem),
    .redirect (redirect)
  );

  memory_stage #(
    .dmem_depth (dmem_depth)
  ) i_memory (
    .clk    (clk),
    .rst_n  (rst_n),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release lands 2 ns after an edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

/* dv/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb import cpu_pkg::*; ();

  localparam int pattern_depth  = 256;
  // program words fill the bottom of the patterns file
  localparam int prog_words     = 64;
  localparam int count_addr     = 64;
  localparam int pair_base      = 65;
  localparam int max_retires    = (pattern_depth - pair_base) / 2;
  localparam int retire_timeout = 2000;
  localparam int reset_timeout  = 50;
  localparam int drain_cycles   = 40;
  localparam int drive_delay    = 2;

  logic                clk;
  logic                rst_n;
  logic [pc_width-1:0] fetch_addr;
  word_t               fetch_data;
  wb_t                 retire;

  word_t       patterns [pattern_depth];
  int unsigned errors;
  int unsigned retired;
  int unsigned expected_count;

  clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cpu_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .retire     (retire)
  );

  ////////////////////////////////////////////////////////////
  // instruction memory
  ////////////////////////////////////////////////////////////

  function automatic word_t imem_word(logic [pc_width-1:0] addr);
    word_t word;
    if (addr < prog_words) begin
      word = patterns[addr];
    end else begin
      word = '0;
    end
    return word;
  endfunction

  // pc only moves on the edge, so the word is settled 2 ns later
  always @(posedge clk) begin
    #(drive_delay);
    fetch_data = imem_word(fetch_addr);
  end

  ////////////////////////////////////////////////////////////
  // retire monitor
  ////////////////////////////////////////////////////////////

  // groups follow the program order in the patterns file
  function automatic string test_name(int unsigned idx);
    string name;
    if (idx < 2) name = "alu_ops";
    else if (idx < 4) name = "forwarding";
    else if (idx < 9) name = "alu_ops";
    else if (idx < 12) name = "memory";
    else if (idx < 14) name = "reg_zero";
    else if (idx < 15) name = "branch_not_taken";
    else name = "branch_taken";
    return name;
  endfunction

  task automatic check_retire(input reg_idx_t dst, input word_t data);
    int unsigned exp_dst;
    word_t       exp_data;
    if (retired >= expected_count) begin
      $display("ERROR: unexpected write of %h to r%0d after the last expected retire",
               data, dst);
      errors++;
    end else begin
      exp_dst  = patterns[pair_base + 2 * retired];
      exp_data = patterns[pair_base + 2 * retired + 1];
      if ((dst != exp_dst) || (data !== exp_data)) begin
        $display("MISMATCH %s retire %0d: expected r%0d = %h, actual r%0d = %h",
                 test_name(retired), retired, exp_dst, exp_data, dst, data);
        errors++;
      end
      retired++;
    end
  endtask

  // sampled mid-cycle, well away from the mem/wb update
  always @(negedge clk) begin
    if (rst_n && retire.valid && retire.reg_write) begin
      check_retire(retire.dst, retire.data);
    end
  end

  ////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////

  task automatic check_reset;
    int   cycles;
    int   i;
    logic released;
    cycles   = 0;
    released = 1'b0;
    while (!released && (cycles < reset_timeout)) begin
      @(negedge clk);
      cycles++;
      if (rst_n) begin
        released = 1'b1;
      end else if (retire.valid !== 1'b0) begin
        $display("ERROR: retire valid is not low while reset is asserted");
        errors++;
      end
    end
    if (!released) begin
      $display("ERROR: reset was not released within %0d cycles", reset_timeout);
      errors++;
    end else begin
      if (fetch_addr !== '0) begin
        $display("MISMATCH reset fetch_addr: expected %h, actual %h", 10'h000, fetch_addr);
        errors++;
      end
      // pipeline is still filling for four cycles
      for (i = 0; i < 4; i++) begin
        if (retire.valid !== 1'b0) begin
          $display("ERROR: retire valid went high %0d cycles after reset release", i);
          errors++;
        end
        @(negedge clk);
      end
      if (retire.valid !== 1'b1) begin
        $display("MISMATCH reset first_retire_valid: expected %b, actual %b",
                 1'b1, retire.valid);
        errors++;
      end
    end
  endtask

  task automatic wait_for_retires;
    int cycles;
    cycles = 0;
    while ((retired < expected_count) && (cycles < retire_timeout)) begin
      @(posedge clk);
      cycles++;
    end
    if (retired < expected_count) begin
      $display("ERROR: timed out after %0d cycles with %0d of %0d retires seen",
               retire_timeout, retired, expected_count);
      errors++;
    end
  endtask

  initial begin
    fetch_data     = '0;
    errors         = 0;
    retired        = 0;
    for (int i = 0; i < pattern_depth; i++) begin
      patterns[i] = '0;
    end
    $readmemh("dv/cpu_patterns.txt", patterns);
    expected_count = patterns[count_addr];
    if ((expected_count == 0) || (expected_count > max_retires)) begin
      $display("ERROR: patterns file gives an invalid retire count of %0d", expected_count);
      errors++;
    end

    check_reset();
    wait_for_retires();
    // the closing branch-to-self keeps running, any stray write shows up here
    repeat (drain_cycles) @(posedge clk);

    $display("errors: %0d, register-write retires checked: %0d of %0d",
             errors, retired, expected_count);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* dv/cpu_patterns.txt */
// words 00..3f: program, one instruction word per line
// @40: number of register-write retires, then one destination and value pair per line
20010005  // addi r1, r0, 5
20020003  // addi r2, r0, 3
00221820  // add  r3, r1, r2
00612022  // sub  r4, r3, r1
00222824  // and  r5, r1, r2
00223025  // or   r6, r1, r2
0041382a  // slt  r7, r2, r1
2009fffe  // addi r9, r0, -2
0121502a  // slt  r10, r9, r1
200b0010  // addi r11, r0, 16
ad660004  // sw   r6, 4(r11)
8d6c0004  // lw   r12, 4(r11)
01836820  // add  r13, r12, r3
20000009  // addi r0, r0, 9
00017020  // add  r14, r0, r1
10220005  // beq  r1, r2, 5
200f000b  // addi r15, r0, 11
102e0002  // beq  r1, r14, 2
20100063  // addi r16, r0, 99
20110062  // addi r17, r0, 98
20120015  // addi r18, r0, 21
024f9820  // add  r19, r18, r15
1000ffff  // beq  r0, r0, -1
@40
00000011
00000001 00000005
00000002 00000003
00000003 00000008
00000004 00000003
00000005 00000001
00000006 00000007
00000007 00000001
00000009 fffffffe
0000000a 00000001
0000000b 00000010
0000000c 00000007
0000000d 0000000f
00000000 00000009
0000000e 00000005
0000000f 0000000b
00000012 00000015
00000013 00000020

/* build.f */
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
dv/clock_gen.sv
dv/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_pipeline

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/fetch_stage.sv
      - logic/register_file.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/cpu_top.sv
  - target: test
    files:
      - dv/clock_gen.sv
      - dv/cpu_tb.sv
